// ==== hdl/rsa_cfg.svh ====
`ifndef RSA_CFG_SVH
`define RSA_CFG_SVH

// operand width, shared by key, exponent and data
`define RSA_BITWIDTH 256

// peripheral register map, byte addresses
`define RSA_RX_BASE     0
`define RSA_TX_BASE     4
`define RSA_STATUS_BASE 8

// status flag positions
`define RSA_TX_OK_BIT 6  // transmitter can take a byte
`define RSA_RX_OK_BIT 7  // received byte waiting

`endif

// ==== hdl/rsa_types_pkg.sv ====
`default_nettype none

package rsa_types_pkg;

`include "rsa_cfg.svh"

    // one full operand: modulus, exponent, cipher or plain text
    typedef logic [`RSA_BITWIDTH-1:0] rsa_word_t;

    // walks the bits of an operand
    typedef logic [$clog2(`RSA_BITWIDTH)-1:0] rsa_bit_idx_t;

    // exponentiation controller
    typedef enum logic [1:0] {
        core_idle = 2'd0,
        core_run  = 2'd1,  // product units busy on one exponent bit
        core_done = 2'd2
    } core_state_t;

endpackage

`default_nettype wire

// ==== hdl/avm_types_pkg.sv ====
`default_nettype none

package avm_types_pkg;

`include "rsa_cfg.svh"

    typedef logic [4:0]  avm_addr_t;
    typedef logic [31:0] avm_data_t;
    typedef logic [7:0]  avm_byte_t;  // payload of one peripheral access

    // byte position inside one operand
    typedef logic [$clog2(`RSA_BITWIDTH/8)-1:0] byte_cnt_t;

    typedef enum logic [2:0] {
        get_key_n = 3'd0,
        get_key_d = 3'd1,
        get_data  = 3'd2,
        req_calc  = 3'd3,
        wait_calc = 3'd4,
        send_data = 3'd5
    } wrap_state_t;

    // per-byte handshake with the peripheral
    typedef enum logic {
        io_wait = 1'b0,  // polling status
        io_work = 1'b1   // rx or tx access on the bus
    } io_state_t;

endpackage

`default_nettype wire

// ==== hdl/rsa_modprod.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "rsa_cfg.svh"

// interleaved multiply and reduce, one bit of b per cycle
module rsa_modprod
    import rsa_types_pkg::*;
(
    input  logic      avm_clk,
    input  logic      avm_rst,
    input  logic      start,
    input  rsa_word_t a,
    input  rsa_word_t b,
    input  rsa_word_t n,
    output rsa_word_t product,
    output logic      done
);

    // 2r + a stays below 3n, two spare bits are enough
    localparam int WIDE = `RSA_BITWIDTH + 2;

    logic            busy;
    rsa_bit_idx_t    idx;   // current bit of b, msb first
    rsa_word_t       rem;   // running remainder, always < n
    rsa_word_t       rem_next;
    logic [WIDE-1:0] n_wide;
    logic [WIDE-1:0] acc;
    logic [WIDE-1:0] red1;
    logic [WIDE-1:0] red2;

    assign n_wide = {2'b00, n};

    // one step: double, conditionally add, pull back under n
    always_comb begin
        acc = {1'b0, rem, 1'b0};
        if (b[idx]) begin
            acc = acc + {2'b00, a};
        end
        red1     = (acc >= n_wide) ? acc - n_wide : acc;
        red2     = (red1 >= n_wide) ? red1 - n_wide : red1;
        rem_next = red2[`RSA_BITWIDTH-1:0];
    end

    always_ff @(posedge avm_clk or posedge avm_rst) begin
        if (avm_rst) begin
            busy <= 1'b0;
            idx  <= '0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy <= 1'b1;
                idx  <= '1;  // top bit of b
            end else if (busy) begin
                if (idx == '0) begin
                    busy <= 1'b0;
                    done <= 1'b1;  // rem holds the product from here on
                end else begin
                    idx <= idx - 1'b1;
                end
            end
        end
    end

    always_ff @(posedge avm_clk) begin
        if (start) begin
            rem <= '0;
        end else if (busy) begin
            rem <= rem_next;
        end
    end

    assign product = rem;

endmodule

`default_nettype wire

// ==== hdl/rsa_core.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "rsa_cfg.svh"

// a^d mod n, exponent scanned from bit 0 upward
module rsa_core
    import rsa_types_pkg::*;
(
    input  logic      avm_clk,
    input  logic      avm_rst,
    input  logic      start,
    input  rsa_word_t a,
    input  rsa_word_t d,
    input  rsa_word_t n,
    output rsa_word_t a_pow_d,
    output logic      finished
);

    localparam rsa_bit_idx_t LAST_BIT = rsa_bit_idx_t'(`RSA_BITWIDTH - 1);

    core_state_t  state;
    rsa_bit_idx_t bit_idx;     // exponent bit being processed
    logic         prod_start;  // kicks both product units together
    logic         mul_done;
    logic         sqr_done;
    logic         step_done;
    rsa_word_t    mul_out;
    rsa_word_t    sqr_out;
    rsa_word_t    base;        // a^(2^bit_idx) mod n
    rsa_word_t    result;

    // result * base, kept only when the exponent bit is set
    rsa_modprod mul_i (
        .avm_clk (avm_clk),
        .avm_rst (avm_rst),
        .start   (prod_start),
        .a       (result),
        .b       (base),
        .n       (n),
        .product (mul_out),
        .done    (mul_done)
    );

    // base squared for the next bit
    rsa_modprod sqr_i (
        .avm_clk (avm_clk),
        .avm_rst (avm_rst),
        .start   (prod_start),
        .a       (base),
        .b       (base),
        .n       (n),
        .product (sqr_out),
        .done    (sqr_done)
    );

    // both units run in lockstep
    assign step_done = mul_done && sqr_done;

    always_ff @(posedge avm_clk or posedge avm_rst) begin
        if (avm_rst) begin
            state      <= core_idle;
            bit_idx    <= '0;
            prod_start <= 1'b0;
            finished   <= 1'b0;
        end else begin
            prod_start <= 1'b0;
            finished   <= 1'b0;
            case (state)
                core_idle: begin
                    if (start) begin
                        bit_idx    <= '0;
                        prod_start <= 1'b1;
                        state      <= core_run;
                    end
                end
                core_run: begin
                    if (step_done) begin
                        if (bit_idx == LAST_BIT) begin
                            state <= core_done;
                        end else begin
                            bit_idx    <= bit_idx + 1'b1;
                            prod_start <= 1'b1;
                        end
                    end
                end
                core_done: begin
                    finished <= 1'b1;  // result settled one cycle earlier
                    state    <= core_idle;
                end
                default: state <= core_idle;
            endcase
        end
    end

    always_ff @(posedge avm_clk) begin
        if (state == core_idle && start) begin
            base   <= a;
            result <= rsa_word_t'(1);
        end else if (state == core_run && step_done) begin
            base <= sqr_out;
            if (d[bit_idx]) begin
                result <= mul_out;
            end
        end
    end

    assign a_pow_d = result;

endmodule

`default_nettype wire

// ==== hdl/rsa_wrapper.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "rsa_cfg.svh"

// byte-wise Avalon master between the serial peripheral and the core
module rsa_wrapper
    import rsa_types_pkg::*;
    import avm_types_pkg::*;
(
    input  logic      avm_clk,
    input  logic      avm_rst,
    output avm_addr_t avm_address,
    output logic      avm_read,
    output logic      avm_write,
    input  avm_data_t avm_readdata,
    output avm_data_t avm_writedata,
    input  logic      avm_waitrequest,
    output logic      core_start,
    output rsa_word_t core_a,
    output rsa_word_t core_d,
    output rsa_word_t core_n,
    input  rsa_word_t core_result,
    input  logic      core_finished
);

    localparam avm_addr_t RX_ADDR     = avm_addr_t'(`RSA_RX_BASE);
    localparam avm_addr_t TX_ADDR     = avm_addr_t'(`RSA_TX_BASE);
    localparam avm_addr_t STATUS_ADDR = avm_addr_t'(`RSA_STATUS_BASE);

    localparam byte_cnt_t RX_LAST = byte_cnt_t'(`RSA_BITWIDTH/8 - 1);
    localparam byte_cnt_t TX_LAST = byte_cnt_t'(`RSA_BITWIDTH/8 - 2);  // top byte never sent

    // control
    wrap_state_t state_r, state_w;
    wrap_state_t rx_next;  // where to go after the current operand
    io_state_t   io_r, io_w;
    byte_cnt_t   byte_cnt_r, byte_cnt_w;
    avm_addr_t   addr_r, addr_w;
    logic        read_r, read_w;
    logic        write_r, write_w;
    logic        start_r, start_w;

    // operands and plain text
    rsa_word_t n_r, n_w;
    rsa_word_t d_r, d_w;
    rsa_word_t enc_r, enc_w;
    rsa_word_t dec_r, dec_w;

    avm_byte_t rx_byte;
    avm_byte_t tx_byte;

    assign rx_byte = avm_readdata[7:0];
    assign tx_byte = dec_r[`RSA_BITWIDTH-9 -: 8];  // byte 30 first

    assign avm_address   = addr_r;
    assign avm_read      = read_r;
    assign avm_write     = write_r;
    assign avm_writedata = avm_data_t'(tx_byte);

    assign core_start = start_r;
    assign core_a     = enc_r;
    assign core_d     = d_r;
    assign core_n     = n_r;

    always_comb begin
        state_w    = state_r;
        io_w       = io_r;
        byte_cnt_w = byte_cnt_r;
        addr_w     = addr_r;
        read_w     = read_r;
        write_w    = write_r;
        start_w    = 1'b0;
        n_w        = n_r;
        d_w        = d_r;
        enc_w      = enc_r;
        dec_w      = dec_r;
        rx_next    = state_r;

        case (state_r)
            get_key_n, get_key_d, get_data: begin
                if (!avm_waitrequest) begin
                    if (io_r == io_wait) begin
                        if (avm_readdata[`RSA_RX_OK_BIT]) begin
                            read_w = 1'b1;
                            addr_w = RX_ADDR;
                            io_w   = io_work;
                        end
                    end else begin
                        // read completes this edge
                        read_w = 1'b0;
                        addr_w = STATUS_ADDR;
                        io_w   = io_wait;
                        case (state_r)
                            get_key_n: begin
                                n_w     = {n_r[`RSA_BITWIDTH-9:0], rx_byte};
                                rx_next = get_key_d;
                            end
                            get_key_d: begin
                                d_w     = {d_r[`RSA_BITWIDTH-9:0], rx_byte};
                                rx_next = get_data;
                            end
                            default: begin
                                enc_w   = {enc_r[`RSA_BITWIDTH-9:0], rx_byte};
                                rx_next = req_calc;
                            end
                        endcase
                        if (byte_cnt_r == RX_LAST) begin
                            byte_cnt_w = '0;
                            state_w    = rx_next;
                        end else begin
                            byte_cnt_w = byte_cnt_t'(byte_cnt_r + 1'b1);
                        end
                    end
                end
            end
            req_calc: begin
                start_w = 1'b1;  // single cycle pulse
                state_w = wait_calc;
            end
            wait_calc: begin
                if (core_finished) begin
                    dec_w   = core_result;
                    state_w = send_data;
                end
            end
            send_data: begin
                if (!avm_waitrequest) begin
                    if (io_r == io_wait) begin
                        if (avm_readdata[`RSA_TX_OK_BIT]) begin
                            write_w = 1'b1;
                            addr_w  = TX_ADDR;
                            io_w    = io_work;
                        end
                    end else begin
                        write_w = 1'b0;
                        addr_w  = STATUS_ADDR;
                        io_w    = io_wait;
                        dec_w   = {dec_r[`RSA_BITWIDTH-9:0], 8'h00};  // next byte up
                        if (byte_cnt_r == TX_LAST) begin
                            byte_cnt_w = '0;
                            state_w    = get_key_n;  // wait for a new key
                        end else begin
                            byte_cnt_w = byte_cnt_t'(byte_cnt_r + 1'b1);
                        end
                    end
                end
            end
            default: begin
                state_w = get_key_n;
            end
        endcase
    end

    always_ff @(posedge avm_clk or posedge avm_rst) begin
        if (avm_rst) begin
            state_r    <= get_key_n;
            io_r       <= io_wait;
            byte_cnt_r <= '0;
            addr_r     <= STATUS_ADDR;
            read_r     <= 1'b0;
            write_r    <= 1'b0;
            start_r    <= 1'b0;
        end else begin
            state_r    <= state_w;
            io_r       <= io_w;
            byte_cnt_r <= byte_cnt_w;
            addr_r     <= addr_w;
            read_r     <= read_w;
            write_r    <= write_w;
            start_r    <= start_w;
        end
    end

    always_ff @(posedge avm_clk) begin
        n_r   <= n_w;
        d_r   <= d_w;
        enc_r <= enc_w;
        dec_r <= dec_w;
    end

endmodule

`default_nettype wire

// ==== hdl/rsa_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module rsa_top
    import rsa_types_pkg::*;
    import avm_types_pkg::*;
(
    input  logic      avm_clk,
    input  logic      avm_rst,
    output avm_addr_t avm_address,
    output logic      avm_read,
    input  avm_data_t avm_readdata,
    output logic      avm_write,
    output avm_data_t avm_writedata,
    input  logic      avm_waitrequest
);

    logic      core_start;
    logic      core_finished;
    rsa_word_t core_a;  // cipher text
    rsa_word_t core_d;
    rsa_word_t core_n;
    rsa_word_t core_result;

    rsa_wrapper wrapper_i (
        .avm_clk         (avm_clk),
        .avm_rst         (avm_rst),
        .avm_address     (avm_address),
        .avm_read        (avm_read),
        .avm_write       (avm_write),
        .avm_readdata    (avm_readdata),
        .avm_writedata   (avm_writedata),
        .avm_waitrequest (avm_waitrequest),
        .core_start      (core_start),
        .core_a          (core_a),
        .core_d          (core_d),
        .core_n          (core_n),
        .core_result     (core_result),
        .core_finished   (core_finished)
    );

    rsa_core core_i (
        .avm_clk  (avm_clk),
        .avm_rst  (avm_rst),
        .start    (core_start),
        .a        (core_a),
        .d        (core_d),
        .n        (core_n),
        .a_pow_d  (core_result),
        .finished (core_finished)
    );

endmodule

`default_nettype wire

// ==== tb/rsa_assertions.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "rsa_cfg.svh"

// protocol rules on the wrapper's bus strobes and core start
module rsa_assertions
    import avm_types_pkg::*;
(
    input logic      avm_clk,
    input logic      avm_rst,
    input avm_addr_t avm_address,
    input logic      avm_read,
    input logic      avm_write,
    input logic      core_start
);

    localparam avm_addr_t RX_ADDR = avm_addr_t'(`RSA_RX_BASE);
    localparam avm_addr_t TX_ADDR = avm_addr_t'(`RSA_TX_BASE);

    int unsigned violations = 0;  // failed checks so far

    read_write_exclusive: assert property (@(posedge avm_clk) disable iff (avm_rst)
        !(avm_read && avm_write))
        else begin
            $error("read and write strobes high in the same cycle");
            violations++;
        end

    read_on_rx: assert property (@(posedge avm_clk) disable iff (avm_rst)
        avm_read |-> avm_address == RX_ADDR)
        else begin
            $error("read issued to an address other than the rx register");
            violations++;
        end

    write_on_tx: assert property (@(posedge avm_clk) disable iff (avm_rst)
        avm_write |-> avm_address == TX_ADDR)
        else begin
            $error("write issued to an address other than the tx register");
            violations++;
        end

    // start must be a single cycle pulse
    start_single_cycle: assert property (@(posedge avm_clk) disable iff (avm_rst)
        core_start |=> !core_start)
        else begin
            $error("core start held high for more than one cycle");
            violations++;
        end

endmodule

bind rsa_wrapper rsa_assertions assert_i (
    .avm_clk     (avm_clk),
    .avm_rst     (avm_rst),
    .avm_address (avm_address),
    .avm_read    (avm_read),
    .avm_write   (avm_write),
    .core_start  (core_start)
);

`default_nettype wire

// ==== tb/tb_rsa_top.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "rsa_cfg.svh"

module tb_rsa_top
    import rsa_types_pkg::*;
    import avm_types_pkg::*;
;

    localparam avm_addr_t STATUS_ADDR = avm_addr_t'(`RSA_STATUS_BASE);
    localparam int BLOCK_TIMEOUT = 200000;  // cycles, core alone needs about 66k
    localparam int BLOCK_BYTES   = `RSA_BITWIDTH/8 - 1;

    logic      avm_clk;
    logic      avm_rst;
    avm_addr_t avm_address;
    logic      avm_read;
    logic      avm_write;
    avm_data_t avm_readdata;
    avm_data_t avm_writedata;
    logic      avm_waitrequest;

    avm_byte_t   rx_q[$];   // bytes waiting in the peripheral
    avm_byte_t   tx_q[$];   // bytes written by the DUT
    logic        bp_mode;   // random stalls on the bus and flags
    logic [31:0] bus_lfsr;
    logic [31:0] op_lfsr;
    int          err_cnt;
    int          test_cnt;
    int          fail_cnt;
    rsa_word_t   blk_n, blk_d, blk_c;  // shared by random and back-pressure tests

    rsa_top dut_i (
        .avm_clk         (avm_clk),
        .avm_rst         (avm_rst),
        .avm_address     (avm_address),
        .avm_read        (avm_read),
        .avm_readdata    (avm_readdata),
        .avm_write       (avm_write),
        .avm_writedata   (avm_writedata),
        .avm_waitrequest (avm_waitrequest)
    );

    always #10 avm_clk = ~avm_clk;

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // peripheral model, first cycle of every access is always stalled
    always @(posedge avm_clk) begin : bus_model
        logic      busy;
        logic      rnd_wait, rnd_rx, rnd_tx;
        avm_data_t status;
        bus_lfsr = lfsr_next(bus_lfsr);
        rnd_wait = bus_lfsr[0];
        bus_lfsr = lfsr_next(bus_lfsr);
        rnd_rx   = bus_lfsr[0];
        bus_lfsr = lfsr_next(bus_lfsr);
        rnd_tx   = bus_lfsr[0];
        busy     = avm_read || avm_write;
        if (busy && !avm_waitrequest) begin  // access completes on this edge
            if (avm_read) begin
                assert (rx_q.size() > 0) else begin
                    $display("read completed while the rx queue was empty");
                    err_cnt++;
                end
                if (rx_q.size() > 0) begin
                    rx_q.delete(0);
                end
            end else begin
                tx_q.push_back(avm_writedata[7:0]);
            end
        end
        status = '0;
        status[`RSA_RX_OK_BIT] = (rx_q.size() > 0) && !(bp_mode && rnd_rx);
        status[`RSA_TX_OK_BIT] = !(bp_mode && rnd_tx);
        if (busy && avm_waitrequest) begin
            avm_readdata    <= (rx_q.size() > 0) ? avm_data_t'(rx_q[0]) : '0;
            avm_waitrequest <= bp_mode && rnd_wait;
        end else if (busy) begin
            avm_readdata    <= status;
            avm_waitrequest <= 1'b0;
        end else if (!avm_waitrequest) begin
            avm_readdata    <= status;
            avm_waitrequest <= 1'b1;  // a request may start next cycle
        end else begin
            avm_readdata    <= status;
            avm_waitrequest <= bp_mode && rnd_wait;
        end
    end

    // modular exponentiation on double-width products
    function automatic rsa_word_t ref_modexp(input rsa_word_t a, input rsa_word_t e,
                                             input rsa_word_t m);
        logic [2*`RSA_BITWIDTH-1:0] res;
        logic [2*`RSA_BITWIDTH-1:0] base;
        int i;
        res  = 1;
        base = a % m;
        for (i = 0; i < `RSA_BITWIDTH; i++) begin
            if (e[i]) begin
                res = (res * base) % m;
            end
            base = (base * base) % m;
        end
        return res[`RSA_BITWIDTH-1:0];
    endfunction

    task automatic gen_word(output rsa_word_t w);
        int i;
        for (i = 0; i < `RSA_BITWIDTH; i++) begin
            op_lfsr = lfsr_next(op_lfsr);
            w[i]    = op_lfsr[0];
        end
    endtask

    // odd modulus with the top bit set, cipher text below it
    task automatic gen_block(output rsa_word_t n, output rsa_word_t d, output rsa_word_t c);
        gen_word(n);
        gen_word(d);
        gen_word(c);
        n[`RSA_BITWIDTH-1] = 1'b1;
        n[0] = 1'b1;
        c[`RSA_BITWIDTH-1] = 1'b0;
    endtask

    task automatic apply_reset();
        @(negedge avm_clk);
        rx_q.delete();
        tx_q.delete();
        @(posedge avm_clk);
        avm_rst <= 1'b1;
        repeat (8) @(posedge avm_clk);
        avm_rst <= 1'b0;
    endtask

    // msb first: n, then d, then cipher text
    task automatic queue_block(input rsa_word_t n, input rsa_word_t d, input rsa_word_t c);
        int i;
        @(negedge avm_clk);
        for (i = `RSA_BITWIDTH/8 - 1; i >= 0; i--) begin
            rx_q.push_back(n[8*i +: 8]);
        end
        for (i = `RSA_BITWIDTH/8 - 1; i >= 0; i--) begin
            rx_q.push_back(d[8*i +: 8]);
        end
        for (i = `RSA_BITWIDTH/8 - 1; i >= 0; i--) begin
            rx_q.push_back(c[8*i +: 8]);
        end
    endtask

    task automatic wait_tx_bytes(input string name, input int count);
        int cycles;
        cycles = 0;
        while (tx_q.size() < count && cycles < BLOCK_TIMEOUT) begin
            @(negedge avm_clk);
            cycles++;
        end
        assert (tx_q.size() >= count) else begin
            $display("%s: timed out waiting for %0d output bytes, only %0d arrived",
                     name, count, tx_q.size());
            err_cnt++;
        end
    endtask

    // bytes 30 down to 0 of the expected plain text
    task automatic check_block(input string name, input rsa_word_t expect_word,
                               input int offset);
        avm_byte_t exp_byte;
        avm_byte_t act_byte;
        int k;
        for (k = 0; k < BLOCK_BYTES; k++) begin
            exp_byte = expect_word[8*(BLOCK_BYTES-1-k) +: 8];
            act_byte = (offset + k < tx_q.size()) ? tx_q[offset+k] : 'x;
            assert (act_byte === exp_byte) else begin
                $display("ERROR %s: byte %0d expected %02h actual %02h",
                         name, offset + k, exp_byte, act_byte);
                err_cnt++;
            end
        end
    endtask

    task automatic close_test(input string name, input int errs_before);
        test_cnt++;
        if (err_cnt == errs_before) begin
            $display("%s: passed", name);
        end else begin
            fail_cnt++;
            $display("%s: failed with %0d errors", name, err_cnt - errs_before);
        end
    endtask

    task automatic test_reset_state();
        int errs;
        int i;
        errs = err_cnt;
        apply_reset();
        for (i = 0; i < 10; i++) begin  // rx queue empty, wrapper must just poll
            @(negedge avm_clk);
            assert (avm_read === 1'b0 && avm_write === 1'b0) else begin
                $display("ERROR reset_state: read/write expected 0/0 actual %b/%b",
                         avm_read, avm_write);
                err_cnt++;
            end
            assert (avm_address === STATUS_ADDR) else begin
                $display("ERROR reset_state: address expected %0d actual %0d",
                         STATUS_ADDR, avm_address);
                err_cnt++;
            end
        end
        close_test("reset_state", errs);
    endtask

    task automatic test_identity();
        rsa_word_t n, d, c;
        int errs;
        errs = err_cnt;
        apply_reset();
        gen_block(n, d, c);
        d = rsa_word_t'(1);
        queue_block(n, d, c);
        wait_tx_bytes("identity", BLOCK_BYTES);
        check_block("identity", c, 0);
        close_test("identity", errs);
    endtask

    task automatic test_random_block();
        int errs;
        errs = err_cnt;
        apply_reset();
        gen_block(blk_n, blk_d, blk_c);
        queue_block(blk_n, blk_d, blk_c);
        wait_tx_bytes("random_block", BLOCK_BYTES);
        check_block("random_block", ref_modexp(blk_c, blk_d, blk_n), 0);
        close_test("random_block", errs);
    endtask

    task automatic test_backpressure();
        int errs;
        errs = err_cnt;
        bp_mode = 1'b1;
        apply_reset();
        queue_block(blk_n, blk_d, blk_c);
        wait_tx_bytes("backpressure", BLOCK_BYTES);
        repeat (50) @(negedge avm_clk);  // room for a stray extra write
        check_block("backpressure", ref_modexp(blk_c, blk_d, blk_n), 0);
        assert (tx_q.size() == BLOCK_BYTES) else begin
            $display("ERROR backpressure: byte count expected %0d actual %0d",
                     BLOCK_BYTES, tx_q.size());
            err_cnt++;
        end
        assert (rx_q.size() == 0) else begin
            $display("ERROR backpressure: rx bytes left expected 0 actual %0d", rx_q.size());
            err_cnt++;
        end
        bp_mode = 1'b0;
        close_test("backpressure", errs);
    endtask

    task automatic test_back_to_back();
        rsa_word_t n1, d1, c1;
        rsa_word_t n2, d2, c2;
        int errs;
        errs = err_cnt;
        apply_reset();
        gen_block(n1, d1, c1);
        gen_block(n2, d2, c2);
        queue_block(n1, d1, c1);
        wait_tx_bytes("back_to_back", BLOCK_BYTES);
        queue_block(n2, d2, c2);  // wrapper must be back in get_key_n
        wait_tx_bytes("back_to_back", 2*BLOCK_BYTES);
        check_block("back_to_back", ref_modexp(c1, d1, n1), 0);
        check_block("back_to_back", ref_modexp(c2, d2, n2), BLOCK_BYTES);
        close_test("back_to_back", errs);
    endtask

    initial begin
        avm_clk         = 1'b0;
        avm_rst         = 1'b1;
        avm_readdata    = '0;
        avm_waitrequest = 1'b0;
        bp_mode         = 1'b0;
        bus_lfsr        = 32'had55;
        op_lfsr         = 32'had55;
        err_cnt         = 0;
        test_cnt        = 0;
        fail_cnt        = 0;

        test_reset_state();
        test_identity();
        test_random_block();
        test_backpressure();
        test_back_to_back();

        // strobe and start rules watched by the bound checker
        assert (dut_i.wrapper_i.assert_i.violations == 0) else begin
            $display("protocol assertions on the wrapper failed %0d times",
                     dut_i.wrapper_i.assert_i.violations);
            err_cnt++;
        end

        $display("tests run %0d, tests failed %0d, errors %0d", test_cnt, fail_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+hdl
hdl/rsa_types_pkg.sv
hdl/avm_types_pkg.sv
hdl/rsa_modprod.sv
hdl/rsa_core.sv
hdl/rsa_wrapper.sv
hdl/rsa_top.sv
tb/rsa_assertions.sv
tb/tb_rsa_top.sv
